// File: source/core_isa_pkg.sv
// RV64 ISA encodings shared by the core blocks and the testbench.
package core_isa_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;

  typedef logic [31:0]           inst_t;
  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_idx_t;

  // --------------------------------------------------------------------------
  // Major opcodes.
  // --------------------------------------------------------------------------
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // Funct fields of the supported subset.
  localparam logic [2:0] F3_ADD   = 3'b000;
  localparam logic [2:0] F3_SLT   = 3'b010;
  localparam logic [2:0] F3_XOR   = 3'b100;
  localparam logic [2:0] F3_OR    = 3'b110;
  localparam logic [2:0] F3_AND   = 3'b111;
  localparam logic [2:0] F3_DWORD = 3'b011;
  localparam logic [2:0] F3_BEQ   = 3'b000;
  localparam logic [2:0] F3_BNE   = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;
  localparam logic [6:0] F7_BASE  = 7'b0000000;
  localparam logic [6:0] F7_SUB   = 7'b0100000;

  localparam inst_t INST_EBREAK = 32'h0010_0073;

  localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE   = 12'hb00;
  localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET = 12'hb02;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_e;

endpackage

// File: source/core_uarch_pkg.sv
// Core micro-architecture codes for sequencer states, writeback sources and data memory size.
package core_uarch_pkg;

  // --------------------------------------------------------------------------
  // Sequencer states. HALT needs the third bit.
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    ST_FETCH = 3'd0,
    ST_EXEC  = 3'd1,
    ST_MEM   = 3'd2,
    ST_WB    = 3'd3,
    ST_HALT  = 3'd4
  } state_e;

  // Source of the register writeback value.
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2,
    WB_CSR = 2'd3
  } wb_sel_e;

  // Data memory depth in doublewords.
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = 8;

endpackage

// File: source/core_control_fsm.sv
// Instruction sequencer holding the PC, instruction register and halt state.
`timescale 1ns/1ns

module core_control_fsm (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  core_isa_pkg::inst_t   i_inst,
  input  core_isa_pkg::xlen_t   i_next_pc,
  input  logic                  i_is_load,
  input  logic                  i_is_store,
  input  logic                  i_reg_write,
  input  logic                  i_halt_req,
  input  logic                  i_illegal,
  output core_isa_pkg::xlen_t   o_pc,
  output core_isa_pkg::inst_t   o_inst,
  output logic                  o_reg_wen,
  output logic                  o_mem_wen,
  output logic                  o_retire,
  output logic                  o_halt,
  output logic                  o_illegal
);

  core_uarch_pkg::state_e state;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= core_uarch_pkg::ST_FETCH;
      o_pc      <= '0;
      o_illegal <= 1'b0;
    end else begin
      case (state)
        core_uarch_pkg::ST_FETCH: state <= core_uarch_pkg::ST_EXEC;
        core_uarch_pkg::ST_EXEC:
          state <= i_is_load ? core_uarch_pkg::ST_MEM : core_uarch_pkg::ST_WB;
        core_uarch_pkg::ST_MEM:   state <= core_uarch_pkg::ST_WB;
        core_uarch_pkg::ST_WB: begin
          o_pc <= i_next_pc;
          if (i_halt_req || i_illegal) begin
            state     <= core_uarch_pkg::ST_HALT;
            o_illegal <= i_illegal;
          end else begin
            state <= core_uarch_pkg::ST_FETCH;
          end
        end
        default: state <= core_uarch_pkg::ST_HALT;
      endcase
    end
  end

  // Instruction register loads at the edge that ends FETCH.
  always_ff @(posedge i_clk) begin
    if (state == core_uarch_pkg::ST_FETCH) begin
      o_inst <= i_inst;
    end
  end

  // Write enables are gated here so the data blocks never look at the state.
  assign o_mem_wen = (state == core_uarch_pkg::ST_EXEC) && i_is_store;
  assign o_reg_wen = (state == core_uarch_pkg::ST_WB) && i_reg_write;
  assign o_retire  = (state == core_uarch_pkg::ST_WB);
  assign o_halt    = (state == core_uarch_pkg::ST_HALT);

endmodule

// File: source/core_counters.sv
// Machine cycle and retired-instruction counters read through CSRRS.
`timescale 1ns/1ns

module core_counters (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_retire,
  input  logic [core_isa_pkg::CSR_ADDR_W-1:0] i_csr_addr,
  output core_isa_pkg::xlen_t                 o_csr_rdata,
  output logic                                o_csr_valid
);

  core_isa_pkg::xlen_t mcycle;
  core_isa_pkg::xlen_t minstret;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      mcycle <= mcycle + 1'b1;
      if (i_retire) begin
        minstret <= minstret + 1'b1;
      end
    end
  end

  // A read in WB sees minstret before its own retirement is counted.
  always_comb begin
    o_csr_rdata = '0;
    o_csr_valid = 1'b1;
    case (i_csr_addr)
      core_isa_pkg::CSR_MCYCLE:   o_csr_rdata = mcycle;
      core_isa_pkg::CSR_MINSTRET: o_csr_rdata = minstret;
      default:                    o_csr_valid = 1'b0;
    endcase
  end

endmodule

// File: source/core_regfile.sv
// General register file of 32 x 64 bits with two read ports and one write port.
`timescale 1ns/1ns

module core_regfile (
  input  logic                     i_clk,
  input  core_isa_pkg::reg_idx_t   i_ra,
  input  core_isa_pkg::reg_idx_t   i_rb,
  input  core_isa_pkg::reg_idx_t   i_waddr,
  input  core_isa_pkg::xlen_t      i_wdata,
  input  logic                     i_wen,
  output core_isa_pkg::xlen_t      o_rdata_a,
  output core_isa_pkg::xlen_t      o_rdata_b
);

  core_isa_pkg::xlen_t regs [32];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 reads as zero.
  assign o_rdata_a = (i_ra == '0) ? '0 : regs[i_ra];
  assign o_rdata_b = (i_rb == '0) ? '0 : regs[i_rb];

endmodule

// File: source/core_decode.sv
// Instruction decoder for the supported RV64 subset.
`timescale 1ns/1ns

module core_decode (
  input  core_isa_pkg::inst_t                 i_inst,
  input  logic                                i_csr_valid,
  output core_isa_pkg::reg_idx_t              o_ra,
  output core_isa_pkg::reg_idx_t              o_rb,
  output core_isa_pkg::reg_idx_t              o_rd,
  output core_isa_pkg::xlen_t                 o_imm,
  output core_isa_pkg::alu_op_e               o_alu_op,
  output logic                                o_alu_b_imm,
  output logic                                o_is_branch,
  output logic                                o_branch_ne,
  output logic                                o_is_jal,
  output logic                                o_is_load,
  output logic                                o_is_store,
  output logic                                o_reg_write,
  output logic                                o_halt_req,
  output logic                                o_illegal,
  output core_uarch_pkg::wb_sel_e             o_wb_sel,
  output logic [core_isa_pkg::CSR_ADDR_W-1:0] o_csr_addr
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  core_isa_pkg::xlen_t imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode     = i_inst[6:0];
  assign funct3     = i_inst[14:12];
  assign funct7     = i_inst[31:25];
  assign o_ra       = i_inst[19:15];
  assign o_rb       = i_inst[24:20];
  assign o_rd       = i_inst[11:7];
  assign o_csr_addr = i_inst[31:20];

  // Sign-extended immediates.
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_imm       = imm_i;
    o_alu_op    = core_isa_pkg::ALU_ADD;
    o_alu_b_imm = 1'b1;
    o_is_branch = 1'b0;
    o_branch_ne = 1'b0;
    o_is_jal    = 1'b0;
    o_is_load   = 1'b0;
    o_is_store  = 1'b0;
    o_reg_write = 1'b0;
    o_halt_req  = 1'b0;
    o_illegal   = 1'b0;
    o_wb_sel    = core_uarch_pkg::WB_ALU;
    case (opcode)
      core_isa_pkg::OPC_OP_IMM: begin
        o_reg_write = 1'b1;
        o_illegal   = (funct3 != core_isa_pkg::F3_ADD);
      end
      core_isa_pkg::OPC_OP: begin
        o_alu_b_imm = 1'b0;
        o_reg_write = 1'b1;
        case (funct3)
          core_isa_pkg::F3_ADD:
            o_alu_op = (funct7 == core_isa_pkg::F7_SUB) ? core_isa_pkg::ALU_SUB
                                                        : core_isa_pkg::ALU_ADD;
          core_isa_pkg::F3_SLT: o_alu_op = core_isa_pkg::ALU_SLT;
          core_isa_pkg::F3_XOR: o_alu_op = core_isa_pkg::ALU_XOR;
          core_isa_pkg::F3_OR:  o_alu_op = core_isa_pkg::ALU_OR;
          core_isa_pkg::F3_AND: o_alu_op = core_isa_pkg::ALU_AND;
          default:              o_illegal = 1'b1;
        endcase
        // Only ADD may carry the SUB funct7.
        if (funct7 != core_isa_pkg::F7_BASE &&
            !(funct7 == core_isa_pkg::F7_SUB && funct3 == core_isa_pkg::F3_ADD)) begin
          o_illegal = 1'b1;
        end
      end
      core_isa_pkg::OPC_LUI: begin
        o_imm       = imm_u;
        o_alu_op    = core_isa_pkg::ALU_PASS_B;
        o_reg_write = 1'b1;
      end
      core_isa_pkg::OPC_LOAD: begin
        o_is_load   = 1'b1;
        o_reg_write = 1'b1;
        o_wb_sel    = core_uarch_pkg::WB_MEM;
        o_illegal   = (funct3 != core_isa_pkg::F3_DWORD);
      end
      core_isa_pkg::OPC_STORE: begin
        o_imm      = imm_s;
        o_is_store = (funct3 == core_isa_pkg::F3_DWORD);
        o_illegal  = (funct3 != core_isa_pkg::F3_DWORD);
      end
      core_isa_pkg::OPC_BRANCH: begin
        o_imm       = imm_b;
        o_is_branch = 1'b1;
        o_branch_ne = (funct3 == core_isa_pkg::F3_BNE);
        o_illegal   = (funct3 != core_isa_pkg::F3_BEQ) && (funct3 != core_isa_pkg::F3_BNE);
      end
      core_isa_pkg::OPC_JAL: begin
        o_imm       = imm_j;
        o_is_jal    = 1'b1;
        o_reg_write = 1'b1;
        o_wb_sel    = core_uarch_pkg::WB_PC4;
      end
      core_isa_pkg::OPC_SYSTEM: begin
        if (i_inst == core_isa_pkg::INST_EBREAK) begin
          o_halt_req = 1'b1;
        end else if (funct3 == core_isa_pkg::F3_CSRRS && i_csr_valid) begin
          o_reg_write = 1'b1;
          o_wb_sel    = core_uarch_pkg::WB_CSR;
        end else begin
          o_illegal = 1'b1;
        end
      end
      default: o_illegal = 1'b1;
    endcase
    if (o_illegal) begin
      o_reg_write = 1'b0;
      o_is_store  = 1'b0;
      o_is_load   = 1'b0;
    end
  end

endmodule

// File: source/core_alu.sv
// Execute unit computing the ALU result, branch decision, next PC and writeback value.
`timescale 1ns/1ns

module core_alu (
  input  core_isa_pkg::xlen_t     i_rs1,
  input  core_isa_pkg::xlen_t     i_rs2,
  input  core_isa_pkg::xlen_t     i_imm,
  input  core_isa_pkg::xlen_t     i_pc,
  input  core_isa_pkg::alu_op_e   i_alu_op,
  input  logic                    i_alu_b_imm,
  input  logic                    i_is_branch,
  input  logic                    i_branch_ne,
  input  logic                    i_is_jal,
  input  core_isa_pkg::xlen_t     i_mem_rdata,
  input  core_isa_pkg::xlen_t     i_csr_rdata,
  input  core_uarch_pkg::wb_sel_e i_wb_sel,
  output core_isa_pkg::xlen_t     o_result,
  output core_isa_pkg::xlen_t     o_next_pc,
  output core_isa_pkg::xlen_t     o_wb_data
);

  core_isa_pkg::xlen_t op_b;
  core_isa_pkg::xlen_t pc_plus4;
  logic                taken;

  assign op_b     = i_alu_b_imm ? i_imm : i_rs2;
  assign pc_plus4 = i_pc + 64'd4;

  always_comb begin
    case (i_alu_op)
      core_isa_pkg::ALU_SUB: o_result = i_rs1 - op_b;
      core_isa_pkg::ALU_AND: o_result = i_rs1 & op_b;
      core_isa_pkg::ALU_OR:  o_result = i_rs1 | op_b;
      core_isa_pkg::ALU_XOR: o_result = i_rs1 ^ op_b;
      core_isa_pkg::ALU_SLT: o_result = {63'b0, $signed(i_rs1) < $signed(op_b)};
      core_isa_pkg::ALU_PASS_B: o_result = op_b;
      default:               o_result = i_rs1 + op_b;
    endcase
  end

  // BEQ takes on equal and BNE on unequal.
  assign taken     = i_is_branch && ((i_rs1 == i_rs2) ^ i_branch_ne);
  assign o_next_pc = (i_is_jal || taken) ? i_pc + i_imm : pc_plus4;

  always_comb begin
    case (i_wb_sel)
      core_uarch_pkg::WB_MEM: o_wb_data = i_mem_rdata;
      core_uarch_pkg::WB_PC4: o_wb_data = pc_plus4;
      core_uarch_pkg::WB_CSR: o_wb_data = i_csr_rdata;
      default:                o_wb_data = o_result;
    endcase
  end

endmodule

// File: source/core_lsu.sv
// Doubleword load/store unit with a synchronous-read data memory.
`timescale 1ns/1ns

module core_lsu (
  input  logic                i_clk,
  input  core_isa_pkg::xlen_t i_addr,
  input  core_isa_pkg::xlen_t i_wdata,
  input  logic                i_wen,
  output core_isa_pkg::xlen_t o_rdata
);

  core_isa_pkg::xlen_t mem [core_uarch_pkg::DMEM_WORDS];

  logic [core_uarch_pkg::DMEM_AW-1:0] idx;

  // Doubleword index with the byte offset bits dropped.
  assign idx = i_addr[core_uarch_pkg::DMEM_AW+2:3];

  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      mem[idx] <= i_wdata;
    end
    o_rdata <= mem[idx];
  end

endmodule

// File: source/core_top.sv
// Multi-cycle RV64 core top level wiring sequencer, counters and datapath.
`timescale 1ns/1ns

module core_top (
  input  logic                   i_clk,
  input  logic                   i_rst,
  output core_isa_pkg::xlen_t    o_imem_addr,
  input  core_isa_pkg::inst_t    i_imem_data,
  output logic                   o_retire,
  output core_isa_pkg::xlen_t    o_retire_pc,
  output logic                   o_wb_en,
  output core_isa_pkg::reg_idx_t o_wb_rd,
  output core_isa_pkg::xlen_t    o_wb_data,
  output logic                   o_halt,
  output logic                   o_illegal
);

  core_isa_pkg::xlen_t     pc, next_pc, imm, rs1, rs2, alu_result, mem_rdata;
  core_isa_pkg::xlen_t     csr_rdata, wb_data;
  core_isa_pkg::inst_t     inst;
  core_isa_pkg::reg_idx_t  ra, rb, rd;
  core_isa_pkg::alu_op_e   alu_op;
  core_uarch_pkg::wb_sel_e wb_sel;
  logic [core_isa_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic alu_b_imm, is_branch, branch_ne, is_jal, is_load, is_store;
  logic reg_write, halt_req, illegal, csr_valid;
  logic reg_wen, mem_wen, retire;

  // --------------------------------------------------------------------------
  // Control.
  // --------------------------------------------------------------------------
  core_control_fsm u_fsm (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_inst(i_imem_data), .i_next_pc(next_pc),
    .i_is_load(is_load), .i_is_store(is_store), .i_reg_write(reg_write),
    .i_halt_req(halt_req), .i_illegal(illegal),
    .o_pc(pc), .o_inst(inst),
    .o_reg_wen(reg_wen), .o_mem_wen(mem_wen), .o_retire(retire),
    .o_halt(o_halt), .o_illegal(o_illegal)
  );

  core_counters u_cnt (
    .i_clk(i_clk), .i_rst(i_rst), .i_retire(retire),
    .i_csr_addr(csr_addr), .o_csr_rdata(csr_rdata), .o_csr_valid(csr_valid)
  );

  // --------------------------------------------------------------------------
  // Datapath.
  // --------------------------------------------------------------------------
  core_decode u_idu (
    .i_inst(inst), .i_csr_valid(csr_valid),
    .o_ra(ra), .o_rb(rb), .o_rd(rd), .o_imm(imm),
    .o_alu_op(alu_op), .o_alu_b_imm(alu_b_imm),
    .o_is_branch(is_branch), .o_branch_ne(branch_ne), .o_is_jal(is_jal),
    .o_is_load(is_load), .o_is_store(is_store), .o_reg_write(reg_write),
    .o_halt_req(halt_req), .o_illegal(illegal),
    .o_wb_sel(wb_sel), .o_csr_addr(csr_addr)
  );

  core_regfile u_gpr (
    .i_clk(i_clk), .i_ra(ra), .i_rb(rb),
    .i_waddr(rd), .i_wdata(wb_data), .i_wen(reg_wen),
    .o_rdata_a(rs1), .o_rdata_b(rs2)
  );

  core_alu u_exu (
    .i_rs1(rs1), .i_rs2(rs2), .i_imm(imm), .i_pc(pc),
    .i_alu_op(alu_op), .i_alu_b_imm(alu_b_imm),
    .i_is_branch(is_branch), .i_branch_ne(branch_ne), .i_is_jal(is_jal),
    .i_mem_rdata(mem_rdata), .i_csr_rdata(csr_rdata), .i_wb_sel(wb_sel),
    .o_result(alu_result), .o_next_pc(next_pc), .o_wb_data(wb_data)
  );

  // Address is rs1 + imm from the ALU.
  core_lsu u_lsu (
    .i_clk(i_clk), .i_addr(alu_result), .i_wdata(rs2),
    .i_wen(mem_wen), .o_rdata(mem_rdata)
  );

  assign o_imem_addr = pc;
  assign o_retire    = retire;
  assign o_retire_pc = pc;
  assign o_wb_en     = reg_wen;
  assign o_wb_rd     = rd;
  assign o_wb_data   = wb_data;

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock source with a synchronous reset that can be requested again.
`timescale 1ns/1ns

module tb_clock_gen (
  input  logic i_reset_req,
  output logic o_clk,
  output logic o_rst
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 4;

  int rst_cnt = RESET_CYCLES;

  initial o_clk = 1'b0;

  always #HALF_PERIOD o_clk = ~o_clk;

  // Reset stays high for RESET_CYCLES rising edges after power-up or a request.
  always @(negedge o_clk) begin
    if (i_reset_req) begin
      rst_cnt <= RESET_CYCLES;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign o_rst = (rst_cnt != 0);

endmodule

// File: verif/tb_core.sv
// Testbench for the multi-cycle RV64 core with a program table, retire checks and halt checks.
`timescale 1ns/1ns

module tb_core;

  localparam int IMEM_WORDS = 64;
  localparam int MAX_ROWS   = 32;
  localparam int HALT_WATCH = 8;

  logic                   clk;
  logic                   rst;
  logic                   reset_req;
  core_isa_pkg::xlen_t    imem_addr;
  core_isa_pkg::inst_t    imem_data;
  logic                   retire;
  core_isa_pkg::xlen_t    retire_pc;
  logic                   wb_en;
  core_isa_pkg::reg_idx_t wb_rd;
  core_isa_pkg::xlen_t    wb_data;
  logic                   halt;
  logic                   illegal;

  core_isa_pkg::inst_t    imem [IMEM_WORDS];
  // Expected retire records in retire order.
  core_isa_pkg::xlen_t    row_pc  [MAX_ROWS];
  logic                   row_wen [MAX_ROWS];
  core_isa_pkg::reg_idx_t row_rd  [MAX_ROWS];
  core_isa_pkg::xlen_t    row_val [MAX_ROWS];
  logic                   row_cyc [MAX_ROWS];
  core_isa_pkg::xlen_t    ref_x   [32];
  core_isa_pkg::xlen_t    pc_cur;
  logic [31:0]            lfsr;
  int                     n_rows;
  int                     pass_cnt;
  int                     fail_cnt;
  int                     cycles;
  int                     limit;

  tb_clock_gen clk_gen0 (.i_reset_req(reset_req), .o_clk(clk), .o_rst(rst));

  core_top dut0 (
    .i_clk(clk), .i_rst(rst),
    .o_imem_addr(imem_addr), .i_imem_data(imem_data),
    .o_retire(retire), .o_retire_pc(retire_pc),
    .o_wb_en(wb_en), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
    .o_halt(halt), .o_illegal(illegal)
  );

  // --------------------------------------------------------------------------
  // Stimulus helpers.
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int b = 0; b < n; b++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic core_isa_pkg::xlen_t sext12(input logic [11:0] imm);
    return {{52{imm[11]}}, imm};
  endfunction

  function automatic core_isa_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic core_isa_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, core_isa_pkg::OPC_OP};
  endfunction

  function automatic core_isa_pkg::inst_t enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, core_isa_pkg::OPC_LUI};
  endfunction

  function automatic core_isa_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, core_isa_pkg::F3_DWORD, imm[4:0], core_isa_pkg::OPC_STORE};
  endfunction

  function automatic core_isa_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_isa_pkg::OPC_BRANCH};
  endfunction

  function automatic core_isa_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_isa_pkg::OPC_JAL};
  endfunction

  // Places one instruction at the current PC and records what its retirement must show.
  task automatic add_row(input core_isa_pkg::inst_t inst, input logic wen,
                         input core_isa_pkg::reg_idx_t rd, input core_isa_pkg::xlen_t val,
                         input logic cyc);
    imem[pc_cur[7:2]] = inst;
    row_pc[n_rows]    = pc_cur;
    row_wen[n_rows]   = wen;
    row_rd[n_rows]    = rd;
    row_val[n_rows]   = val;
    row_cyc[n_rows]   = cyc;
    if (wen && rd != 0) begin
      ref_x[rd] = val;
    end
    n_rows = n_rows + 1;
    pc_cur = pc_cur + 64'd4;
  endtask

  // --------------------------------------------------------------------------
  // Checks.
  // --------------------------------------------------------------------------
  task automatic check_xlen(input string what, input core_isa_pkg::xlen_t got,
                            input core_isa_pkg::xlen_t exp);
    if (got === exp) begin
      pass_cnt++;
      $display("ok    %s = %h", what, got);
    end else begin
      fail_cnt++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input string what, input core_isa_pkg::reg_idx_t got,
                           input core_isa_pkg::reg_idx_t exp);
    if (got === exp) begin
      pass_cnt++;
      $display("ok    %s = x%0d", what, got);
    end else begin
      fail_cnt++;
      $display("Error at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got === exp) begin
      pass_cnt++;
      $display("ok    %s = %b", what, got);
    end else begin
      fail_cnt++;
      $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic wait_retire();
    do begin
      @(negedge clk);
    end while (retire !== 1'b1);
  endtask

  // The core must stay halted with no further retirements.
  task automatic watch_halt(input logic exp_illegal);
    int extra;
    extra = 0;
    repeat (HALT_WATCH) begin
      @(negedge clk);
      if (retire) begin
        extra++;
      end
    end
    check_bit("halt", halt, 1'b1);
    check_bit("illegal flag", illegal, exp_illegal);
    check_bit("no retire after halt", extra == 0, 1'b1);
  endtask

  always @(negedge clk) begin
    imem_data <= imem[imem_addr[7:2]];
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: the core did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Program table and main sequence.
  // --------------------------------------------------------------------------
  initial begin
    logic [19:0]         u1, u2;
    logic [11:0]         i1, i2, i3;
    core_isa_pkg::xlen_t last_cyc;
    imem_data = '0;
    reset_req = 1'b0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    cycles    = 0;
    n_rows    = 0;
    pc_cur    = '0;
    last_cyc  = '0;
    lfsr      = 32'hf8bad442;
    for (int r = 0; r < 32; r++) begin
      ref_x[r] = '0;
    end
    // Unused words hold an illegal opcode tagged with their index.
    for (int a = 0; a < IMEM_WORDS; a++) begin
      imem[a] = {a[24:0], 7'h7f};
    end
    u1 = lfsr_bits(20);
    i1 = lfsr_bits(12);
    u2 = lfsr_bits(20);
    i2 = lfsr_bits(12);
    i3 = lfsr_bits(12);

    add_row(enc_u(u1, 1), 1'b1, 1, {{32{u1[19]}}, u1, 12'h0}, 1'b0);
    add_row(enc_i(i1, 1, core_isa_pkg::F3_ADD, 1, core_isa_pkg::OPC_OP_IMM), 1'b1, 1,
            ref_x[1] + sext12(i1), 1'b0);
    add_row(enc_u(u2, 2), 1'b1, 2, {{32{u2[19]}}, u2, 12'h0}, 1'b0);
    add_row(enc_i(i2, 2, core_isa_pkg::F3_ADD, 2, core_isa_pkg::OPC_OP_IMM), 1'b1, 2,
            ref_x[2] + sext12(i2), 1'b0);
    add_row(enc_r(core_isa_pkg::F7_BASE, 2, 1, core_isa_pkg::F3_ADD, 3), 1'b1, 3,
            ref_x[1] + ref_x[2], 1'b0);
    add_row(enc_r(core_isa_pkg::F7_SUB, 2, 1, core_isa_pkg::F3_ADD, 4), 1'b1, 4,
            ref_x[1] - ref_x[2], 1'b0);
    add_row(enc_r(core_isa_pkg::F7_BASE, 2, 1, core_isa_pkg::F3_AND, 5), 1'b1, 5,
            ref_x[1] & ref_x[2], 1'b0);
    add_row(enc_r(core_isa_pkg::F7_BASE, 2, 1, core_isa_pkg::F3_OR, 6), 1'b1, 6,
            ref_x[1] | ref_x[2], 1'b0);
    add_row(enc_r(core_isa_pkg::F7_BASE, 2, 1, core_isa_pkg::F3_XOR, 7), 1'b1, 7,
            ref_x[1] ^ ref_x[2], 1'b0);
    add_row(enc_r(core_isa_pkg::F7_BASE, 2, 1, core_isa_pkg::F3_SLT, 8), 1'b1, 8,
            {63'b0, $signed(ref_x[1]) < $signed(ref_x[2])}, 1'b0);
    add_row(enc_r(core_isa_pkg::F7_BASE, 1, 2, core_isa_pkg::F3_SLT, 9), 1'b1, 9,
            {63'b0, $signed(ref_x[2]) < $signed(ref_x[1])}, 1'b0);
    // The x0 write shows on the bus and x0 must still read as zero afterwards.
    add_row(enc_i(i3, 1, core_isa_pkg::F3_ADD, 0, core_isa_pkg::OPC_OP_IMM), 1'b1, 0,
            ref_x[1] + sext12(i3), 1'b0);
    add_row(enc_r(core_isa_pkg::F7_BASE, 1, 0, core_isa_pkg::F3_ADD, 10), 1'b1, 10,
            ref_x[1], 1'b0);

    add_row(enc_i(12'h100, 0, core_isa_pkg::F3_ADD, 11, core_isa_pkg::OPC_OP_IMM), 1'b1, 11,
            64'h100, 1'b0);
    add_row(enc_s(12'd8, 3, 11), 1'b0, 0, '0, 1'b0);
    add_row(enc_i(12'd8, 11, core_isa_pkg::F3_DWORD, 12, core_isa_pkg::OPC_LOAD), 1'b1, 12,
            ref_x[3], 1'b0);

    add_row(enc_b(13'd8, 1, 1, core_isa_pkg::F3_BEQ), 1'b0, 0, '0, 1'b0);
    pc_cur = pc_cur + 64'd4;
    add_row(enc_b(13'd8, 1, 1, core_isa_pkg::F3_BNE), 1'b0, 0, '0, 1'b0);
    add_row(enc_j(21'd12, 13), 1'b1, 13, pc_cur + 64'd4, 1'b0);
    pc_cur = pc_cur + 64'd8;

    add_row(enc_i(core_isa_pkg::CSR_MINSTRET, 0, core_isa_pkg::F3_CSRRS, 14,
                  core_isa_pkg::OPC_SYSTEM), 1'b1, 14, core_isa_pkg::xlen_t'(n_rows), 1'b0);
    add_row(enc_i(core_isa_pkg::CSR_MCYCLE, 0, core_isa_pkg::F3_CSRRS, 15,
                  core_isa_pkg::OPC_SYSTEM), 1'b1, 15, '0, 1'b1);
    add_row(enc_i(core_isa_pkg::CSR_MCYCLE, 0, core_isa_pkg::F3_CSRRS, 16,
                  core_isa_pkg::OPC_SYSTEM), 1'b1, 16, '0, 1'b1);
    add_row(core_isa_pkg::INST_EBREAK, 1'b0, 0, '0, 1'b0);

    // Five cycles per row cover a 4-cycle load and the rerun row.
    limit = 5 * (n_rows + 1) + 2 * HALT_WATCH + 20;

    for (int r = 0; r < n_rows; r++) begin
      wait_retire();
      check_xlen("retire pc", retire_pc, row_pc[r]);
      check_bit("wb enable", wb_en, row_wen[r]);
      if (row_wen[r]) begin
        check_reg("wb rd", wb_rd, row_rd[r]);
        if (row_cyc[r]) begin
          check_bit("mcycle increasing", wb_data > last_cyc, 1'b1);
          check_bit("mcycle covers 3 per retire", wb_data >= core_isa_pkg::xlen_t'(3 * r), 1'b1);
          last_cyc = wb_data;
        end else begin
          check_xlen("wb data", wb_data, row_val[r]);
        end
      end
    end
    watch_halt(1'b0);

    // Rerun from reset with an illegal word at the reset vector.
    imem[0] = 32'hffff_ffff;
    @(posedge clk);
    reset_req = 1'b1;
    @(posedge clk);
    reset_req = 1'b0;
    wait_retire();
    check_xlen("illegal retire pc", retire_pc, '0);
    check_bit("illegal wb enable", wb_en, 1'b0);
    watch_halt(1'b1);

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: project.f
source/core_isa_pkg.sv
source/core_uarch_pkg.sv
source/core_control_fsm.sv
source/core_counters.sv
source/core_regfile.sv
source/core_decode.sv
source/core_alu.sv
source/core_lsu.sv
source/core_top.sv
verif/tb_clock_gen.sv
verif/tb_core.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_core -f project.f -o sim_core

./obj_dir/sim_core | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
